/* test/track_stim.mem */
// one record per line: kind chan flag hhh vvv rgbw, as 13 hex digits
// kind 1 pixel, 2 frame end, 3 expect (chan 0 cr / 1 cb, flag 1 pulse due), 4 test end
// red F800 at (100,50), cr mask only
100064032F800
2000000000000
3010640320000
3100000000000
4000000000000
// blue pixels, mean h 34/3 rounds down to 11, black pixel ignored
10000A014001F
10000B014001F
10000D017001F
1001F41F40000
2000000000000
3000640320000
31100B0150000
4000000000000
// red and blue mixed, each channel from its own pixels
1000C8064F800
1000C9065F800
10012C190001F
10012E191001F
100131195001F
2000000000000
3010C80640000
31112E1920000
4000000000000
// black, green, white, no mask anywhere
1000320320000
10003C03C07E0
100046046FFFF
2000000000000
3000C80640000
31012E1920000
4000000000000
// red at the far corner, mean rounds down on both axes
1004FF2CFF800
1004FE2CEF800
2000000000000
3014FE2CE0000
31012E1920000
4000000000000

/* sim.f */
+incdir+rtl
rtl/track_pkg.sv
rtl/color_convert.sv
rtl/chroma_threshold.sv
rtl/centroid_divider.sv
rtl/centroid_accum.sv
rtl/track_top.sv
test/tb_track_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with verilator from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module tb_track_top \
  --Mdir obj_dir -o tb_track_top

./obj_dir/tb_track_top > sim.log
cat sim.log

# the log decides the result
if grep -qx "sim passed" sim.log; then
  exit 0
else
  exit 1
fi

/* test/tb_track_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "track_cfg.svh"

module tb_track_top import track_pkg::*; ();

  // frame_end at pixel_i to centroid valid, whole pipeline
  localparam int LATENCY     = 39;
  // observation window after each frame_end, a little past the latency
  localparam int WINDOW      = 45;
  localparam int MAX_RECORDS = 64;

  // record kinds in the stim file
  localparam logic [3:0] REC_END       = 4'h0;
  localparam logic [3:0] REC_PIXEL     = 4'h1;
  localparam logic [3:0] REC_FRAME_END = 4'h2;
  localparam logic [3:0] REC_EXPECT    = 4'h3;
  localparam logic [3:0] REC_TEST_END  = 4'h4;

  logic        clk_camera;
  logic        sys_rst_pixel;
  pixel_beat_t pixel_i;
  coord_t      centroid_cr;
  coord_t      centroid_cb;
  logic        centroid_cr_valid;
  logic        centroid_cb_valid;

  // kind, chan, flag, h, v, rgb565 word
  logic [51:0] stim_mem [0:MAX_RECORDS-1];
  logic [31:0] rng_state;
  int          error_count;
  int          test_count;
  int          failed_tests;
  int          test_errors_start;
  int          cycle_count;
  int          cycle_limit;
  // high while valid pulses are expected
  logic        in_window;
  // pulses seen in the last window and the cycle of the first one
  int          cr_pulses;
  int          cb_pulses;
  int          cr_first;
  int          cb_first;

  track_top u_track_top (
    .clk_camera          (clk_camera),
    .sys_rst_pixel       (sys_rst_pixel),
    .pixel_i             (pixel_i),
    .centroid_cr_o       (centroid_cr),
    .centroid_cb_o       (centroid_cb),
    .centroid_cr_valid_o (centroid_cr_valid),
    .centroid_cb_valid_o (centroid_cb_valid)
  );

  initial clk_camera = 1'b0;
  always #2 clk_camera = ~clk_camera;

  // idle gaps between pixels
  function automatic logic [31:0] xorshift32(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic compare_values(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      error_count++;
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk_camera);
    #1;
  endtask

  task automatic drive_pixel(input logic [`TRACK_H_BITS-1:0] h,
                             input logic [`TRACK_V_BITS-1:0] v,
                             input logic [15:0] rgb);
    rng_state = xorshift32(rng_state);
    repeat (rng_state[1:0]) begin
      next_cycle();
      pixel_i = '0;
    end
    next_cycle();
    pixel_i           = '0;
    pixel_i.valid     = 1'b1;
    pixel_i.coord.h   = h;
    pixel_i.coord.v   = v;
    pixel_i.pixel.raw = rgb;
  endtask

  // one frame_end beat, then watch both valid outputs
  task automatic close_frame();
    int i;
    next_cycle();
    pixel_i           = '0;
    pixel_i.frame_end = 1'b1;
    in_window         = 1'b1;
    cr_pulses         = 0;
    cb_pulses         = 0;
    cr_first          = 0;
    cb_first          = 0;
    for (i = 1; i <= WINDOW; i++) begin
      next_cycle();
      pixel_i = '0;
      // i rising edges have passed since the beat was driven
      @(negedge clk_camera);
      if (centroid_cr_valid) begin
        if (cr_pulses == 0) cr_first = i;
        cr_pulses++;
      end
      if (centroid_cb_valid) begin
        if (cb_pulses == 0) cb_first = i;
        cb_pulses++;
      end
    end
    next_cycle();
    in_window = 1'b0;
  endtask

  task automatic check_expect(input logic [3:0] chan, input logic [3:0] flag,
                              input logic [11:0] h, input logic [11:0] v);
    int     pulses;
    int     first;
    coord_t got;
    string  tag;
    if (chan == 4'h0) begin
      pulses = cr_pulses;
      first  = cr_first;
      got    = centroid_cr;
      tag    = "cr";
    end else begin
      pulses = cb_pulses;
      first  = cb_first;
      got    = centroid_cb;
      tag    = "cb";
    end
    if (flag != 4'h0) begin
      if (pulses == 0) begin
        $display("test %0d: no %s valid pulse after frame_end", test_count + 1, tag);
        error_count++;
      end else begin
        if (pulses > 1) begin
          $display("test %0d: %s valid stayed high for %0d cycles", test_count + 1,
                   tag, pulses);
          error_count++;
        end
        compare_values({"centroid_", tag, "_valid_o latency"}, first, LATENCY);
      end
    end else if (pulses != 0) begin
      $display("test %0d: unexpected %s valid pulse after frame_end", test_count + 1, tag);
      error_count++;
    end
    // held value, new or unchanged
    compare_values({"centroid_", tag, "_o.h"}, 32'(got.h), 32'(h));
    compare_values({"centroid_", tag, "_o.v"}, 32'(got.v), 32'(v));
  endtask

  task automatic finish_test();
    test_count++;
    if (error_count == test_errors_start) begin
      $display("test %0d: ok", test_count);
    end else begin
      failed_tests++;
      $display("test %0d: %0d errors", test_count, error_count - test_errors_start);
    end
    test_errors_start = error_count;
  endtask

  // valid must never rise outside a frame_end window
  always @(negedge clk_camera) begin
    if (!sys_rst_pixel && !in_window && (centroid_cr_valid || centroid_cb_valid)) begin
      $display("centroid valid pulse with no frame_end pending, cycle %0d", cycle_count);
      error_count++;
    end
  end

  always @(posedge clk_camera) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run did not end within %0d cycles", cycle_limit);
      $display("sim failed");
      $finish;
    end
  end

  initial begin
    int          idx;
    int          n_records;
    int          n_frames;
    logic [51:0] rec;
    sys_rst_pixel     = 1'b1;
    pixel_i           = '0;
    in_window         = 1'b0;
    rng_state         = 32'd30635;
    error_count       = 0;
    test_count        = 0;
    failed_tests      = 0;
    test_errors_start = 0;
    cycle_count       = 0;
    cycle_limit       = 1000000;
    cr_pulses         = 0;
    cb_pulses         = 0;
    cr_first          = 0;
    cb_first          = 0;
    for (idx = 0; idx < MAX_RECORDS; idx++) stim_mem[idx] = '0;
    $readmemh("test/track_stim.mem", stim_mem);

    // run length bound from the stimulus itself
    n_records = 0;
    n_frames  = 0;
    while (n_records < MAX_RECORDS && stim_mem[n_records][51:48] != REC_END) begin
      if (stim_mem[n_records][51:48] == REC_FRAME_END) n_frames++;
      n_records++;
    end
    cycle_limit = n_records * 4 + 60 * n_frames;

    repeat (4) @(posedge clk_camera);
    #1;
    sys_rst_pixel = 1'b0;

    // test 1, idle outputs after reset
    repeat (8) begin
      next_cycle();
      compare_values("centroid_cr_valid_o", 32'(centroid_cr_valid), 32'd0);
      compare_values("centroid_cb_valid_o", 32'(centroid_cb_valid), 32'd0);
      compare_values("centroid_cr_o", 32'(centroid_cr), 32'd0);
      compare_values("centroid_cb_o", 32'(centroid_cb), 32'd0);
    end
    finish_test();

    for (idx = 0; idx < n_records; idx++) begin
      rec = stim_mem[idx];
      case (rec[51:48])
        REC_PIXEL:     drive_pixel(rec[38:28], rec[25:16], rec[15:0]);
        REC_FRAME_END: close_frame();
        REC_EXPECT:    check_expect(rec[47:44], rec[43:40], rec[39:28], rec[27:16]);
        REC_TEST_END:  finish_test();
        default: begin
          $display("record %0d has an unknown kind %0h", idx, rec[51:48]);
          error_count++;
        end
      endcase
    end

    repeat (4) next_cycle();
    $display("tests: %0d run, %0d failed, %0d errors", test_count, failed_tests,
             error_count);
    if (error_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/track_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "track_cfg.svh"

module track_top import track_pkg::*; (
  input  wire               clk_camera,
  input  wire               sys_rst_pixel,
  input  wire pixel_beat_t  pixel_i,
  output coord_t            centroid_cr_o,
  output coord_t            centroid_cb_o,
  output logic              centroid_cr_valid_o,
  output logic              centroid_cb_valid_o
);

  // 3 cycles of conversion, 1 of threshold
  chroma_beat_t chroma_beat;
  mask_beat_t   mask_beat;
  // copy of the mask beat with the cb mask moved into the mask_cr slot
  mask_beat_t   cb_beat;

  color_convert u_color_convert (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .beat_i        (pixel_i),
    .beat_o        (chroma_beat)
  );

  chroma_threshold u_chroma_threshold (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .beat_i        (chroma_beat),
    .beat_o        (mask_beat)
  );

  // accumulators only look at mask_cr
  assign cb_beat = '{valid:     mask_beat.valid,
                     frame_end: mask_beat.frame_end,
                     coord:     mask_beat.coord,
                     mask_cr:   mask_beat.mask_cb,
                     mask_cb:   1'b0};

  centroid_accum u_accum_cr (
    .clk_camera       (clk_camera),
    .sys_rst_pixel    (sys_rst_pixel),
    .beat_i           (mask_beat),
    .centroid_o       (centroid_cr_o),
    .centroid_valid_o (centroid_cr_valid_o)
  );

  centroid_accum u_accum_cb (
    .clk_camera       (clk_camera),
    .sys_rst_pixel    (sys_rst_pixel),
    .beat_i           (cb_beat),
    .centroid_o       (centroid_cb_o),
    .centroid_valid_o (centroid_cb_valid_o)
  );

endmodule

`default_nettype wire

/* rtl/centroid_accum.sv */
`timescale 1ns/1ps
`default_nettype none

`include "track_cfg.svh"

module centroid_accum import track_pkg::*; (
  input  wire              clk_camera,
  input  wire              sys_rst_pixel,
  input  wire mask_beat_t  beat_i,
  output coord_t           centroid_o,
  output logic             centroid_valid_o
);

  // running totals of the current frame
  logic [`TRACK_SUM_BITS-1:0] sum_h_q;
  logic [`TRACK_SUM_BITS-1:0] sum_v_q;
  logic [`TRACK_CNT_BITS-1:0] cnt_q;
  // frame totals held for the dividers
  logic [`TRACK_SUM_BITS-1:0] tot_h_q;
  logic [`TRACK_SUM_BITS-1:0] tot_v_q;
  logic [`TRACK_CNT_BITS-1:0] tot_cnt_q;

  logic                       start_q;
  logic                       busy_q;
  logic                       frame_close;
  logic                       both_done;
  logic [`TRACK_SUM_BITS-1:0] h_ext;
  logic [`TRACK_SUM_BITS-1:0] v_ext;
  logic [`TRACK_SUM_BITS-1:0] quo_h;
  logic [`TRACK_SUM_BITS-1:0] quo_v;
  logic                       done_h;
  logic                       done_v;

  // a frame_end during a divide is dropped
  assign frame_close = beat_i.frame_end && !busy_q;
  // both axes start together so they finish together
  assign both_done   = done_h && done_v;
  assign h_ext = {{(`TRACK_SUM_BITS - `TRACK_H_BITS){1'b0}}, beat_i.coord.h};
  assign v_ext = {{(`TRACK_SUM_BITS - `TRACK_V_BITS){1'b0}}, beat_i.coord.v};

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      sum_h_q <= '0;
      sum_v_q <= '0;
      cnt_q   <= '0;
    end else if (frame_close) begin
      sum_h_q <= '0;
      sum_v_q <= '0;
      cnt_q   <= '0;
    end else if (beat_i.mask_cr) begin
      // mask bit is already gated by valid upstream
      sum_h_q <= sum_h_q + h_ext;
      sum_v_q <= sum_v_q + v_ext;
      cnt_q   <= cnt_q + `TRACK_CNT_BITS'(1);
    end
  end

  always_ff @(posedge clk_camera) begin
    if (frame_close) begin
      tot_h_q   <= sum_h_q;
      tot_v_q   <= sum_v_q;
      tot_cnt_q <= cnt_q;
    end
  end

  // empty frames skip the divide and keep the old centroid
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      start_q <= 1'b0;
      busy_q  <= 1'b0;
    end else begin
      start_q <= frame_close && (cnt_q != '0);
      if (frame_close && (cnt_q != '0)) begin
        busy_q <= 1'b1;
      end else if (both_done) begin
        busy_q <= 1'b0;
      end
    end
  end

  centroid_divider u_div_h (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .start_i       (start_q),
    .dividend_i    (tot_h_q),
    .divisor_i     (tot_cnt_q),
    .quotient_o    (quo_h),
    .done_o        (done_h)
  );

  centroid_divider u_div_v (
    .clk_camera    (clk_camera),
    .sys_rst_pixel (sys_rst_pixel),
    .start_i       (start_q),
    .dividend_i    (tot_v_q),
    .divisor_i     (tot_cnt_q),
    .quotient_o    (quo_v),
    .done_o        (done_v)
  );

  // hold register, the mean always fits the coordinate width
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      centroid_o       <= '0;
      centroid_valid_o <= 1'b0;
    end else begin
      centroid_valid_o <= both_done;
      if (both_done) begin
        centroid_o.h <= quo_h[`TRACK_H_BITS-1:0];
        centroid_o.v <= quo_v[`TRACK_V_BITS-1:0];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/centroid_divider.sv */
`timescale 1ns/1ps
`default_nettype none

`include "track_cfg.svh"

module centroid_divider (
  input  wire                        clk_camera,
  input  wire                        sys_rst_pixel,
  input  wire                        start_i,
  input  wire [`TRACK_SUM_BITS-1:0]  dividend_i,
  input  wire [`TRACK_CNT_BITS-1:0]  divisor_i,
  output logic [`TRACK_SUM_BITS-1:0] quotient_o,
  output logic                       done_o
);

  localparam int unsigned STEP_BITS = $clog2(`TRACK_SUM_BITS);

  logic                       busy_q;
  logic [STEP_BITS-1:0]       step_q;
  logic [`TRACK_CNT_BITS-1:0] divisor_q;
  // remainder always stays below the divisor
  logic [`TRACK_CNT_BITS-1:0] rem_q;
  logic [`TRACK_CNT_BITS:0]   shifted;
  logic [`TRACK_CNT_BITS+1:0] trial;

  // next dividend bit comes off the top of the quotient shift register
  assign shifted = {rem_q, quotient_o[`TRACK_SUM_BITS-1]};
  assign trial   = {1'b0, shifted} - {2'b00, divisor_q};

  // one load cycle, then one bit per cycle
  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      busy_q <= 1'b0;
      step_q <= '0;
      done_o <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i && !busy_q) begin
        busy_q <= 1'b1;
        step_q <= '0;
      end else if (busy_q) begin
        step_q <= step_q + STEP_BITS'(1);
        // last bit lands together with done
        if (step_q == STEP_BITS'(`TRACK_SUM_BITS - 1)) begin
          busy_q <= 1'b0;
          done_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (start_i && !busy_q) begin
      quotient_o <= dividend_i;
      rem_q      <= '0;
      divisor_q  <= divisor_i;
    end else if (busy_q) begin
      // restore by simply keeping the shifted value
      if (!trial[`TRACK_CNT_BITS+1]) begin
        rem_q      <= trial[`TRACK_CNT_BITS-1:0];
        quotient_o <= {quotient_o[`TRACK_SUM_BITS-2:0], 1'b1};
      end else begin
        rem_q      <= shifted[`TRACK_CNT_BITS-1:0];
        quotient_o <= {quotient_o[`TRACK_SUM_BITS-2:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/chroma_threshold.sv */
`timescale 1ns/1ps
`default_nettype none

`include "track_cfg.svh"

module chroma_threshold import track_pkg::*; (
  input  wire                clk_camera,
  input  wire                sys_rst_pixel,
  input  wire chroma_beat_t  beat_i,
  output mask_beat_t         beat_o
);

  logic cr_in_window;
  logic cb_in_window;

  // both window edges inclusive
  assign cr_in_window = (beat_i.cr >= `TRACK_LOWER_BOUND) &&
                        (beat_i.cr <= `TRACK_UPPER_BOUND);
  assign cb_in_window = (beat_i.cb >= `TRACK_LOWER_BOUND) &&
                        (beat_i.cb <= `TRACK_UPPER_BOUND);

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      beat_o.valid     <= 1'b0;
      beat_o.frame_end <= 1'b0;
      beat_o.mask_cr   <= 1'b0;
      beat_o.mask_cb   <= 1'b0;
    end else begin
      beat_o.valid     <= beat_i.valid;
      beat_o.frame_end <= beat_i.frame_end;
      // idle and frame_end beats never count as masked
      beat_o.mask_cr   <= beat_i.valid && cr_in_window;
      beat_o.mask_cb   <= beat_i.valid && cb_in_window;
    end
    beat_o.coord <= beat_i.coord;
  end

endmodule

`default_nettype wire

/* rtl/color_convert.sv */
`timescale 1ns/1ps
`default_nettype none

`include "track_cfg.svh"

module color_convert import track_pkg::*; (
  input  wire               clk_camera,
  input  wire               sys_rst_pixel,
  input  wire pixel_beat_t  beat_i,
  output chroma_beat_t      beat_o
);

  // stage 1, expanded channels plus sideband
  logic       s1_valid;
  logic       s1_frame_end;
  coord_t     s1_coord;
  logic [7:0] s1_r;
  logic [7:0] s1_g;
  logic [7:0] s1_b;

  // stage 2, rounded weighted sums
  logic              s2_valid;
  logic              s2_frame_end;
  coord_t            s2_coord;
  logic signed [17:0] s2_cr_sum;
  logic signed [17:0] s2_cb_sum;

  // signed views of the 8 bit channels
  logic signed [17:0] r_ext;
  logic signed [17:0] g_ext;
  logic signed [17:0] b_ext;
  logic signed [17:0] cr_mix;
  logic signed [17:0] cb_mix;
  logic signed [17:0] cr_shift;
  logic signed [17:0] cb_shift;

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      s1_valid     <= 1'b0;
      s1_frame_end <= 1'b0;
    end else begin
      s1_valid     <= beat_i.valid;
      s1_frame_end <= beat_i.frame_end;
    end
    s1_coord <= beat_i.coord;
    // zero fill the low bits, 5:6:5 to 8:8:8
    s1_r <= {beat_i.pixel.rgb.red, 3'b000};
    s1_g <= {beat_i.pixel.rgb.green, 2'b00};
    s1_b <= {beat_i.pixel.rgb.blue, 3'b000};
  end

  assign r_ext = $signed({10'd0, s1_r});
  assign g_ext = $signed({10'd0, s1_g});
  assign b_ext = $signed({10'd0, s1_b});

  // worst case magnitude 112*255 + 128, fits 18 bit signed
  assign cr_mix = `TRACK_CR_R * r_ext - `TRACK_CR_G * g_ext - `TRACK_CR_B * b_ext
                  + `TRACK_CHROMA_ROUND;
  assign cb_mix = `TRACK_CB_B * b_ext - `TRACK_CB_R * r_ext - `TRACK_CB_G * g_ext
                  + `TRACK_CHROMA_ROUND;

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      s2_valid     <= 1'b0;
      s2_frame_end <= 1'b0;
    end else begin
      s2_valid     <= s1_valid;
      s2_frame_end <= s1_frame_end;
    end
    s2_coord  <= s1_coord;
    s2_cr_sum <= cr_mix;
    s2_cb_sum <= cb_mix;
  end

  // arithmetic shift keeps the sign of negative sums
  assign cr_shift = s2_cr_sum >>> 8;
  assign cb_shift = s2_cb_sum >>> 8;

  always_ff @(posedge clk_camera) begin
    if (sys_rst_pixel) begin
      beat_o.valid     <= 1'b0;
      beat_o.frame_end <= 1'b0;
    end else begin
      beat_o.valid     <= s2_valid;
      beat_o.frame_end <= s2_frame_end;
    end
    beat_o.coord <= s2_coord;
    // offset wraps modulo 256, only the low byte is kept
    beat_o.cr <= cr_shift[7:0] + `TRACK_CHROMA_OFFSET;
    beat_o.cb <= cb_shift[7:0] + `TRACK_CHROMA_OFFSET;
  end

endmodule

`default_nettype wire

/* rtl/track_pkg.sv */
`default_nettype none

`include "track_cfg.svh"

package track_pkg;

  // rgb565 field split of one camera word
  typedef struct packed {
    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
  } rgb565_t;

  // raw view as the word arrives, rgb view for the colour math
  typedef union packed {
    logic [15:0] raw;
    rgb565_t     rgb;
  } pixel_word_u;

  // pixel position in the frame
  typedef struct packed {
    logic [`TRACK_H_BITS-1:0] h;
    logic [`TRACK_V_BITS-1:0] v;
  } coord_t;

  // input beat, frame_end beats carry no pixel
  typedef struct packed {
    logic        valid;
    logic        frame_end;
    coord_t      coord;
    pixel_word_u pixel;
  } pixel_beat_t;

  // after colour conversion
  typedef struct packed {
    logic       valid;
    logic       frame_end;
    coord_t     coord;
    logic [7:0] cr;
    logic [7:0] cb;
  } chroma_beat_t;

  // after thresholding, masks already qualified by valid
  typedef struct packed {
    logic   valid;
    logic   frame_end;
    coord_t coord;
    logic   mask_cr;
    logic   mask_cb;
  } mask_beat_t;

endpackage

`default_nettype wire

/* rtl/track_cfg.svh */
`ifndef TRACK_CFG_SVH
`define TRACK_CFG_SVH

// frame coordinate widths
`define TRACK_H_BITS 11
`define TRACK_V_BITS 10

// per-frame coordinate sums, also the divider dividend
`define TRACK_SUM_BITS 32
// masked pixel count, enough for a full 1280x720 frame
`define TRACK_CNT_BITS 21

// inclusive chroma window, shared by cr and cb
`define TRACK_LOWER_BOUND 8'hA0
`define TRACK_UPPER_BOUND 8'hF0

// cr weights, applied as 112r - 94g - 18b
`define TRACK_CR_R 18'sd112
`define TRACK_CR_G 18'sd94
`define TRACK_CR_B 18'sd18

// cb weights, applied as -38r - 74g + 112b
`define TRACK_CB_R 18'sd38
`define TRACK_CB_G 18'sd74
`define TRACK_CB_B 18'sd112

// rounding term before the shift and the offset after it
`define TRACK_CHROMA_ROUND 18'sd128
`define TRACK_CHROMA_OFFSET 8'd128

`endif
